/* hw/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  localparam int NUM_SUPER = 2;   // Instructions per fetch group
  localparam int BLOCK_W   = 64;  // Memory and cache block
  localparam int INST_W    = 32;
  localparam int OFF_W     = 3;   // Byte offset bits within a block

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // Zero means no transaction
  typedef logic [3:0] mem_tag_t;

  typedef struct packed {
    logic [63:0]                      pc;          // Aligned down to the block
    logic [NUM_SUPER-1:0][INST_W-1:0] ir;          // Slot 0 is the lower address
    logic [NUM_SUPER-1:0]             slot_valid;
  } fetch_group_t;

  // Tag bits left over once offset and index are taken from a 64-bit PC
  function automatic int tag_width(input int num_lines);
    return 64 - OFF_W - $clog2(num_lines);
  endfunction

endpackage

`default_nettype wire

/* hw/icache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem #(
  parameter  int NUM_LINES = 32,
  localparam int IDX_W     = $clog2(NUM_LINES),
  localparam int TAG_W     = frontend_pkg::tag_width(NUM_LINES)
) (
  input  logic                             clock,
  input  logic                             rst,
  input  logic [IDX_W-1:0]                 rd_idx,
  input  logic [TAG_W-1:0]                 rd_tag,
  output logic [frontend_pkg::BLOCK_W-1:0] rd_data,
  output logic                             rd_hit,
  input  logic                             wr_en,
  input  logic [IDX_W-1:0]                 wr_idx,
  input  logic [TAG_W-1:0]                 wr_tag,
  input  logic [frontend_pkg::BLOCK_W-1:0] wr_data
);

  import frontend_pkg::*;

  logic [NUM_LINES-1:0] line_valid;
  logic [TAG_W-1:0]     tags  [NUM_LINES];
  logic [BLOCK_W-1:0]   lines [NUM_LINES];

  always_ff @(posedge clock) begin
    if (rst) begin
      line_valid <= '0;
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_idx]  <= wr_tag;
      lines[wr_idx] <= wr_data;
    end
  end

  // Lookup is combinational and a fill shows up after the edge
  assign rd_data = lines[rd_idx];
  assign rd_hit  = line_valid[rd_idx] && (tags[rd_idx] == rd_tag);

  a_wr_en_known: assert property (
    @(posedge clock) disable iff (rst) !$isunknown(wr_en)
  );

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter  int NUM_LINES = 32,
  localparam int IDX_W     = $clog2(NUM_LINES),
  localparam int TAG_W     = frontend_pkg::tag_width(NUM_LINES)
) (
  input  logic                             clock,
  input  logic                             rst,
  input  logic [63:0]                      fetch_pc,
  output logic [frontend_pkg::BLOCK_W-1:0] block,
  output logic                             block_valid,
  output logic [IDX_W-1:0]                 rd_idx,
  output logic [TAG_W-1:0]                 rd_tag,
  input  logic [frontend_pkg::BLOCK_W-1:0] rd_data,
  input  logic                             rd_hit,
  output logic                             wr_en,
  output logic [IDX_W-1:0]                 wr_idx,
  output logic [TAG_W-1:0]                 wr_tag,
  output logic [frontend_pkg::BLOCK_W-1:0] wr_data,
  input  frontend_pkg::mem_tag_t           mem2proc_response,
  input  logic [frontend_pkg::BLOCK_W-1:0] mem2proc_data,
  input  frontend_pkg::mem_tag_t           mem2proc_tag,
  output frontend_pkg::bus_cmd_e           proc2mem_command,
  output logic [63:0]                      proc2mem_addr
);

  import frontend_pkg::*;

  logic        req_pending;   // BUS_LOAD held until memory takes it
  logic        fill_pending;  // Waiting for the tag to come back
  mem_tag_t    fill_tag;
  logic [63:0] line_addr;     // Block address of the miss
  logic        start_req;
  logic        accepted;

  assign rd_idx      = fetch_pc[OFF_W +: IDX_W];
  assign rd_tag      = fetch_pc[63 -: TAG_W];
  assign block       = rd_data;
  assign block_valid = rd_hit;

  // Only one miss in flight at a time
  assign start_req = !rd_hit && !req_pending && !fill_pending;
  assign accepted  = req_pending && (mem2proc_response != '0);

  assign proc2mem_command = req_pending ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = line_addr;

  assign wr_en   = fill_pending && (mem2proc_tag == fill_tag);
  assign wr_idx  = line_addr[OFF_W +: IDX_W];
  assign wr_tag  = line_addr[63 -: TAG_W];
  assign wr_data = mem2proc_data;

  always_ff @(posedge clock) begin
    if (rst) begin
      req_pending  <= 1'b0;
      fill_pending <= 1'b0;
      fill_tag     <= '0;
    end else if (start_req) begin
      req_pending <= 1'b1;
    end else if (accepted) begin
      req_pending  <= 1'b0;
      fill_pending <= 1'b1;
      fill_tag     <= mem2proc_response;
    end else if (wr_en) begin
      fill_pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start_req) begin
      line_addr <= {fetch_pc[63:OFF_W], {OFF_W{1'b0}}};
    end
  end

  // Once memory takes a request the bus stays quiet until that fill lands
  a_single_fill: assert property (
    @(posedge clock) disable iff (rst)
    accepted |=> (proc2mem_command != BUS_LOAD) until_with wr_en
  );

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic                             clock,
  input  logic                             rst,
  output logic [63:0]                      fetch_pc,
  input  logic [frontend_pkg::BLOCK_W-1:0] block,
  input  logic                             block_valid,
  input  logic                             full,
  input  logic                             rollback_en,
  input  logic [63:0]                      rollback_pc,
  output frontend_pkg::fetch_group_t       group,
  output logic                             push
);

  import frontend_pkg::*;

  logic [63:0]      pc;
  logic [63:0]      pc_aligned;
  logic [OFF_W-3:0] first_slot;   // Word within the block

  assign fetch_pc   = pc;
  assign pc_aligned = {pc[63:OFF_W], {OFF_W{1'b0}}};
  assign first_slot = pc[OFF_W-1:2];

  // A group leaves only on a hit with room and no redirect
  assign push = block_valid && !full && !rollback_en;

  always_comb begin
    group.pc = pc_aligned;
    group.ir = block;   // Lower address sits in the low half
    for (int i = 0; i < NUM_SUPER; i++) begin
      group.slot_valid[i] = (i >= first_slot);
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (rollback_en) begin
      pc <= rollback_pc;
    end else if (push) begin
      pc <= pc_aligned + 64'(BLOCK_W / 8);   // Next block boundary
    end
  end

  a_pc_word_aligned: assert property (
    @(posedge clock) disable iff (rst) pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

/* hw/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
  parameter  int FB_DEPTH = 8,
  localparam int PTR_W    = $clog2(FB_DEPTH),
  localparam int CNT_W    = $clog2(FB_DEPTH + 1)
) (
  input  logic                       clock,
  input  logic                       rst,
  input  frontend_pkg::fetch_group_t group,
  input  logic                       push,
  output logic                       full,
  input  logic                       take,
  input  logic                       rollback_en,
  output frontend_pkg::fetch_group_t group_out,
  output logic                       group_valid
);

  import frontend_pkg::*;

  fetch_group_t     entries [FB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(FB_DEPTH));
  assign group_valid = (count != '0);
  assign group_out   = entries[head];
  assign pop         = take && group_valid;

  always_ff @(posedge clock) begin
    if (rst || rollback_en) begin   // Rollback drops everything queued
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= ptr_inc(tail);
      end
      if (pop) begin
        head <= ptr_inc(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      entries[tail] <= group;
    end
  end

  // Fetch owns the stall, so a push into a full queue is a fetch bug
  a_no_push_full: assert property (
    @(posedge clock) disable iff (rst) push |-> !full
  );

  a_count_bound: assert property (
    @(posedge clock) disable iff (rst) count <= CNT_W'(FB_DEPTH)
  );

endmodule

`default_nettype wire

/* hw/frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend #(
  parameter int          NUM_LINES = 32,
  parameter int          FB_DEPTH  = 8,
  parameter logic [63:0] RESET_PC  = 64'h0
) (
  input  logic                             clock,
  input  logic                             rst,
  input  frontend_pkg::mem_tag_t           mem2proc_response,
  input  logic [frontend_pkg::BLOCK_W-1:0] mem2proc_data,
  input  frontend_pkg::mem_tag_t           mem2proc_tag,
  output frontend_pkg::bus_cmd_e           proc2mem_command,
  output logic [63:0]                      proc2mem_addr,
  output frontend_pkg::fetch_group_t       group_out,
  output logic                             group_valid,
  input  logic                             take,
  input  logic                             rollback_en,
  input  logic [63:0]                      rollback_pc
);

  import frontend_pkg::*;

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = tag_width(NUM_LINES);

  logic [IDX_W-1:0]   rd_idx;
  logic [TAG_W-1:0]   rd_tag;
  logic [BLOCK_W-1:0] rd_data;
  logic               rd_hit;
  logic               wr_en;
  logic [IDX_W-1:0]   wr_idx;
  logic [TAG_W-1:0]   wr_tag;
  logic [BLOCK_W-1:0] wr_data;
  logic [63:0]        fetch_pc;
  logic [BLOCK_W-1:0] block;
  logic               block_valid;
  fetch_group_t       group;
  logic               push;
  logic               full;

  icache_mem #(
    .NUM_LINES (NUM_LINES)
  ) i_icache_mem (
    .clock   (clock),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .rd_data (rd_data),
    .rd_hit  (rd_hit),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_data (wr_data)
  );

  icache_ctrl #(
    .NUM_LINES (NUM_LINES)
  ) i_icache_ctrl (
    .clock             (clock),
    .rst               (rst),
    .fetch_pc          (fetch_pc),
    .block             (block),
    .block_valid       (block_valid),
    .rd_idx            (rd_idx),
    .rd_tag            (rd_tag),
    .rd_data           (rd_data),
    .rd_hit            (rd_hit),
    .wr_en             (wr_en),
    .wr_idx            (wr_idx),
    .wr_tag            (wr_tag),
    .wr_data           (wr_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr)
  );

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) i_fetch_stage (
    .clock       (clock),
    .rst         (rst),
    .fetch_pc    (fetch_pc),
    .block       (block),
    .block_valid (block_valid),
    .full        (full),
    .rollback_en (rollback_en),
    .rollback_pc (rollback_pc),
    .group       (group),
    .push        (push)
  );

  fetch_buffer #(
    .FB_DEPTH (FB_DEPTH)
  ) i_fetch_buffer (
    .clock       (clock),
    .rst         (rst),
    .group       (group),
    .push        (push),
    .full        (full),
    .take        (take),
    .rollback_en (rollback_en),
    .group_out   (group_out),
    .group_valid (group_valid)
  );

endmodule

`default_nettype wire

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter logic [31:0] SEED        = 32'h1,
  parameter int          MAX_LATENCY = 10
) (
  input  logic                             clock,
  input  logic                             rst,
  input  int                               busy_pct,
  input  frontend_pkg::bus_cmd_e           proc2mem_command,
  input  logic [63:0]                      proc2mem_addr,
  output frontend_pkg::mem_tag_t           mem2proc_response,
  output logic [frontend_pkg::BLOCK_W-1:0] mem2proc_data,
  output frontend_pkg::mem_tag_t           mem2proc_tag
);

  import frontend_pkg::*;

  integer      seed;
  logic        busy;
  logic        outstanding;   // One fill at a time
  mem_tag_t    next_tag;
  mem_tag_t    fill_tag;
  logic [63:0] fill_addr;
  int          wait_cnt;

  function automatic logic [31:0] word_at(input logic [63:0] addr);
    logic [63:0] shifted;
    shifted = addr >> 3;
    return (addr[31:0] * 32'h9e3779b1) ^ shifted[31:0];
  endfunction

  initial begin
    seed          = SEED;
    busy          = 1'b0;
    outstanding   = 1'b0;
    next_tag      = 4'h1;
    mem2proc_tag  = '0;
    mem2proc_data = '0;
  end

  // Accept only when idle and not busy this cycle
  always_comb begin
    if (proc2mem_command == BUS_LOAD && !busy && !outstanding) begin
      mem2proc_response = next_tag;
    end else begin
      mem2proc_response = '0;
    end
  end

  always @(posedge clock) begin
    mem2proc_tag <= '0;
    if (rst) begin
      busy        <= 1'b0;
      outstanding <= 1'b0;
      next_tag    <= 4'h1;
    end else begin
      busy <= ($unsigned($random(seed)) % 100) < busy_pct;
      if (mem2proc_response != '0) begin
        outstanding <= 1'b1;
        fill_tag    <= mem2proc_response;
        fill_addr   <= proc2mem_addr;
        wait_cnt    <= 1 + $unsigned($random(seed)) % MAX_LATENCY;
        next_tag    <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;   // Skip tag 0
      end else if (outstanding) begin
        if (wait_cnt == 1) begin
          outstanding   <= 1'b0;
          mem2proc_tag  <= fill_tag;
          mem2proc_data <= {word_at(fill_addr + 64'd4), word_at(fill_addr)};
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  import frontend_pkg::*;

  localparam int          NUM_LINES = 32;
  localparam int          FB_DEPTH  = 8;
  localparam logic [63:0] RESET_PC  = 64'h0;
  localparam logic [31:0] SEED      = 32'h80197ca8;

  logic               clock;
  logic               rst;
  mem_tag_t           mem2proc_response;
  logic [BLOCK_W-1:0] mem2proc_data;
  mem_tag_t           mem2proc_tag;
  bus_cmd_e           proc2mem_command;
  logic [63:0]        proc2mem_addr;
  fetch_group_t       group_out;
  logic               group_valid;
  logic               take;
  logic               rollback_en;
  logic [63:0]        rollback_pc;
  int                 busy_pct;

  integer             seed;
  int                 error_count;
  int                 check_count;
  int                 test_count;
  int                 failed_tests;
  int                 errors_before;   // Error count when the current test began
  int                 pop_count;
  logic [63:0]        exp_pc;          // Next pc the stream should pop
  fetch_group_t       expected;
  logic               record_lines;
  logic               reuse_check;
  logic [63:0]        cached_lines[$];
  logic               fill_in_flight;
  mem_tag_t           inflight_tag;

  frontend #(
    .NUM_LINES (NUM_LINES),
    .FB_DEPTH  (FB_DEPTH),
    .RESET_PC  (RESET_PC)
  ) i_frontend (
    .clock             (clock),
    .rst               (rst),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .group_out         (group_out),
    .group_valid       (group_valid),
    .take              (take),
    .rollback_en       (rollback_en),
    .rollback_pc       (rollback_pc)
  );

  tb_mem_model #(
    .SEED (SEED)
  ) i_mem_model (
    .clock             (clock),
    .rst               (rst),
    .busy_pct          (busy_pct),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] inst_at(input logic [63:0] addr);
    logic [63:0] shifted;
    shifted = addr >> 3;
    return (addr[31:0] * 32'h9e3779b1) ^ shifted[31:0];
  endfunction

  function automatic fetch_group_t expected_group(input logic [63:0] pc);
    fetch_group_t g;
    g.pc = {pc[63:3], 3'b000};
    for (int i = 0; i < NUM_SUPER; i++) begin
      g.ir[i] = inst_at(g.pc + 64'(4 * i));
    end
    g.slot_valid = {1'b1, !pc[2]};   // Slot 0 only from an aligned pc
    return g;
  endfunction

  function automatic bit line_seen(input logic [63:0] addr);
    foreach (cached_lines[i]) begin
      if (cached_lines[i] == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  task automatic apply_reset();
    rst  <= 1'b1;
    take <= 1'b0;
    repeat (2) @(posedge clock);
    rst <= 1'b0;
  endtask

  task automatic do_rollback(input logic [63:0] target);
    @(posedge clock);
    take        <= 1'b0;
    rollback_en <= 1'b1;
    rollback_pc <= target;
    @(posedge clock);
    rollback_en <= 1'b0;
  endtask

  // Pop n groups with optional random stretches of take low
  task automatic pop_groups(input int n, input bit stalls);
    int   start;
    int   cycles;
    int   hold;
    logic level;
    start  = pop_count;
    cycles = 0;
    hold   = 0;
    level  = 1'b0;
    while (pop_count - start < n && cycles < 150 * n + 500) begin
      @(posedge clock);
      cycles++;
      if (!stalls) begin
        level = 1'b1;
      end else if (hold == 0) begin
        level = !level;
        if (level) begin
          hold = 1 + $unsigned($random(seed)) % 6;
        end else begin
          hold = 1 + $unsigned($random(seed)) % 20;
        end
      end else begin
        hold--;
      end
      take <= level;
    end
    take <= 1'b0;
    if (pop_count - start < n) begin
      $display("timeout: only %0d of %0d groups popped after %0d cycles",
               pop_count - start, n, cycles);
      error_count++;
      failed_tests++;
      finish_run();
    end
  endtask

  // Expected stream checked on every pop
  always @(posedge clock) begin
    if (rst) begin
      exp_pc = RESET_PC;
    end else if (rollback_en) begin
      exp_pc = rollback_pc;
    end else if (take && group_valid) begin
      expected = expected_group(exp_pc);
      check_value("group_out.pc", group_out.pc, expected.pc);
      for (int i = 0; i < NUM_SUPER; i++) begin
        if (expected.slot_valid[i]) begin
          check_value($sformatf("group_out.ir[%0d]", i), group_out.ir[i], expected.ir[i]);
        end
      end
      check_value("group_out.slot_valid", group_out.slot_valid, expected.slot_valid);
      if (record_lines) begin
        cached_lines.push_back(expected.pc);
      end
      exp_pc = expected.pc + 64'd8;
      pop_count <= pop_count + 1;
    end
  end

  // One fill in flight and no reload of a cached line
  always @(posedge clock) begin
    if (rst) begin
      fill_in_flight = 1'b0;
    end else if (fill_in_flight) begin
      check_value("proc2mem_command", proc2mem_command, BUS_NONE);
      if (mem2proc_tag == inflight_tag) begin
        fill_in_flight = 1'b0;
      end
    end else if (proc2mem_command == BUS_LOAD && mem2proc_response != '0) begin
      fill_in_flight = 1'b1;
      inflight_tag   = mem2proc_response;
      if (reuse_check && line_seen(proc2mem_addr)) begin
        error_count++;
        $display("memory load issued again for line %h that was already cached",
                 proc2mem_addr);
      end
    end
  end

  initial begin
    seed         = SEED;
    rst          = 1'b1;
    take         = 1'b0;
    rollback_en  = 1'b0;
    rollback_pc  = '0;
    busy_pct     = 30;
    record_lines = 1'b0;
    reuse_check  = 1'b0;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    pop_count    = 0;

    errors_before = error_count;
    apply_reset();
    @(negedge clock);
    check_value("group_valid", group_valid, 1'b0);
    check_value("proc2mem_command", proc2mem_command, BUS_NONE);
    pop_groups(12, 1'b0);
    end_test("reset and sequential fetch");

    errors_before = error_count;
    repeat (200) @(posedge clock);   // Buffer fills up and stalls fetch
    @(negedge clock);
    check_value("group_valid", group_valid, 1'b1);
    pop_groups(40, 1'b1);
    end_test("back-pressure");

    errors_before = error_count;
    @(posedge clock);
    busy_pct <= 85;
    pop_groups(30, 1'b1);
    busy_pct <= 30;
    end_test("busy memory and random latency");

    errors_before = error_count;
    pop_groups(4, 1'b1);
    repeat (20) @(posedge clock);
    do_rollback(64'h1000);
    pop_groups(6, 1'b1);
    repeat (20) @(posedge clock);
    do_rollback(64'h2004);   // Unaligned target
    pop_groups(6, 1'b1);
    end_test("rollback");

    errors_before = error_count;
    apply_reset();
    cached_lines.delete();
    record_lines <= 1'b1;
    pop_groups(10, 1'b0);
    record_lines <= 1'b0;
    do_rollback(RESET_PC);
    reuse_check <= 1'b1;
    pop_groups(10, 1'b0);
    reuse_check <= 1'b0;
    end_test("cache reuse");

    finish_run();
  end

endmodule

`default_nettype wire

/* frontend.f */
hw/frontend_pkg.sv
hw/icache_mem.sv
hw/icache_ctrl.sv
hw/fetch_stage.sv
hw/fetch_buffer.sv
hw/frontend.sv
verification/tb_mem_model.sv
verification/frontend_tb.sv
